// File: Bender.yml
package:
  name: cpuSm

sources:
  - common/cpuBusPkg.sv
  - common/dmaXferPkg.sv
  - src/busArbiter.sv
  - src/cycleTerminator.sv
  - cpuSm/cpuSmSequencer.sv
  - cpuSm/cpuSm.sv
  - target: sim
    files:
      - sim/cpuSm_properties.sv
      - sim/cpuSmChecker.sv
      - sim/cpuSmTb.sv

// File: common/cpuBusPkg.sv
// bus-side types for arbitration and cycle termination, referenced by scoped name
package cpuBusPkg;

    // flops on every asynchronous input before it reaches logic
    localparam int SYNC_STAGES = 2;

    // bus ownership states
    typedef enum logic [1:0] {
        IDLE    = 2'd0,    // no bus wanted
        REQUEST = 2'd1,    // breq out, waiting for grant and idle bus
        OWNED   = 2'd2,    // bgack driven, cycles may run
        RELEASE = 2'd3     // dead cycle so breq cannot follow bgack
    } arbState_e;

    // port size reported by the slave's termination
    typedef enum logic {
        PORT32 = 1'b0,     // both dsacks or sterm
        PORT16 = 1'b1      // dsack1 alone
    } portWidth_e;

endpackage

// File: common/dmaXferPkg.sv
// transfer-side types for the long-word sequencer and fifo direction, referenced by scoped name
package dmaXferPkg;

    // bus cycles needed for one long word on a 16-bit port
    localparam int MAX_HALVES = 2;

    // one pass through ADDR..ADVANCE moves one long word
    typedef enum logic [2:0] {
        IDLE     = 3'd0,   // waiting for ownership
        ADDR     = 3'd1,   // pas up, pds next
        DATA_HI  = 3'd2,   // first cycle of the word
        DATA_LO  = 3'd3,   // second cycle, narrow port only
        WAIT_END = 3'd4,   // terminations and fifo flags settle
        ADVANCE  = 3'd5,   // next word or stop
        DONE     = 3'd6    // wait for bgack to drop
    } seqState_e;

    // direction as seen from the fifo
    typedef enum logic {
        TO_FIFO   = 1'b0,  // bus read into fifo
        FROM_FIFO = 1'b1   // fifo written out to bus
    } xferDir_e;

endpackage

// File: cpuSm.f
common/cpuBusPkg.sv
common/dmaXferPkg.sv
src/busArbiter.sv
src/cycleTerminator.sv
cpuSm/cpuSmSequencer.sv
cpuSm/cpuSm.sv
sim/cpuSm_properties.sv
sim/cpuSmChecker.sv
sim/cpuSmTb.sv

// File: cpuSm/cpuSm.sv
// top of the cpu-side bus master sequencer, syncs the dma controls and wires the three blocks
`timescale 1ns/1ps

module cpuSm (
    input  logic CLK135,
    input  logic CCRESET_,
    input  logic dmaEna,
    input  logic dreqN,
    input  logic dmaDir,
    input  logic flushFifo,
    input  logic fifoEmpty,
    input  logic fifoFull,
    input  logic bgrantN,
    input  logic bgackInN,
    input  logic asN,
    input  logic dsack0N,
    input  logic dsack1N,
    input  logic stermN,
    output logic breq,
    output logic bgack,
    output logic pas,
    output logic pds,
    output logic size1,
    output logic a1,
    output logic f2cpuH,
    output logic f2cpuL,
    output logic plhw,
    output logic pllw,
    output logic incFifo,
    output logic decFifo,
    output logic incNi,
    output logic incNo,
    output logic stopFlush
);

    // {dmaEna, dreqN, dmaDir, flushFifo, fifoEmpty, fifoFull}
    logic [5:0] ctlSync [cpuBusPkg::SYNC_STAGES];
    logic sDmaEna, sDreqN, sDmaDir, sFlushFifo, sFifoEmpty, sFifoFull;

    logic owned;
    logic wantBus;
    logic xferEnd;
    logic cycDone;
    cpuBusPkg::portWidth_e width;

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            for (int i = 0; i < cpuBusPkg::SYNC_STAGES; i++) begin
                ctlSync[i] <= 6'b010000;    // dreqN idles high
            end
        end else begin
            ctlSync[0] <= {dmaEna, dreqN, dmaDir, flushFifo, fifoEmpty, fifoFull};
            for (int i = 1; i < cpuBusPkg::SYNC_STAGES; i++) begin
                ctlSync[i] <= ctlSync[i-1];
            end
        end
    end

    assign {sDmaEna, sDreqN, sDmaDir, sFlushFifo, sFifoEmpty, sFifoFull} =
        ctlSync[cpuBusPkg::SYNC_STAGES-1];

    busArbiter uArbiter (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .wantBus  (wantBus),
        .bgrantN  (bgrantN),
        .bgackInN (bgackInN),
        .asN      (asN),
        .xferEnd  (xferEnd),
        .breq     (breq),
        .bgack    (bgack),
        .owned    (owned)
    );

    cycleTerminator uTerm (
        .CLK135   (CLK135),
        .CCRESET_ (CCRESET_),
        .pas      (pas),
        .dsack0N  (dsack0N),
        .dsack1N  (dsack1N),
        .stermN   (stermN),
        .cycDone  (cycDone),
        .width    (width)
    );

    cpuSmSequencer uSeq (
        .CLK135    (CLK135),
        .CCRESET_  (CCRESET_),
        .dmaEna    (sDmaEna),
        .dreqN     (sDreqN),
        .dmaDir    (sDmaDir),
        .flushFifo (sFlushFifo),
        .fifoEmpty (sFifoEmpty),
        .fifoFull  (sFifoFull),
        .owned     (owned),
        .cycDone   (cycDone),
        .width     (width),
        .wantBus   (wantBus),
        .xferEnd   (xferEnd),
        .pas       (pas),
        .pds       (pds),
        .size1     (size1),
        .a1        (a1),
        .f2cpuH    (f2cpuH),
        .f2cpuL    (f2cpuL),
        .plhw      (plhw),
        .pllw      (pllw),
        .incFifo   (incFifo),
        .decFifo   (decFifo),
        .incNi     (incNi),
        .incNo     (incNo),
        .stopFlush (stopFlush)
    );

endmodule

// File: cpuSm/cpuSmSequencer.sv
// per-long-word bus cycle sequencer that drives the bus strobes and fifo bookkeeping pulses
`timescale 1ns/1ps

module cpuSmSequencer (
    input  logic                  CLK135,
    input  logic                  CCRESET_,
    input  logic                  dmaEna,
    input  logic                  dreqN,
    input  logic                  dmaDir,
    input  logic                  flushFifo,
    input  logic                  fifoEmpty,
    input  logic                  fifoFull,
    input  logic                  owned,
    input  logic                  cycDone,
    input  cpuBusPkg::portWidth_e width,
    output logic                  wantBus,
    output logic                  xferEnd,
    output logic                  pas,
    output logic                  pds,
    output logic                  size1,
    output logic                  a1,
    output logic                  f2cpuH,
    output logic                  f2cpuL,
    output logic                  plhw,
    output logic                  pllw,
    output logic                  incFifo,
    output logic                  decFifo,
    output logic                  incNi,
    output logic                  incNo,
    output logic                  stopFlush
);

    dmaXferPkg::seqState_e state;
    dmaXferPkg::xferDir_e  dir;
    logic       isWrite;
    logic       limit;
    logic       flushWrite;
    logic       reqOk;
    logic       decide;        // IDLE or ADVANCE, word boundary
    logic       lastCycle;
    logic       narrow;        // slave answered PORT16 on this word
    logic [1:0] halfCnt;       // cycles done in this word
    logic [1:0] settleCnt;
    logic       startLo;
    logic       startCycle;

    assign dir        = dmaXferPkg::xferDir_e'(dmaDir);
    assign isWrite    = (dir == dmaXferPkg::FROM_FIFO);
    assign limit      = isWrite ? fifoEmpty : fifoFull;    // nothing left / no room
    assign flushWrite = flushFifo & isWrite;
    assign reqOk      = dmaEna & (~dreqN | flushWrite) & ~limit;

    assign decide    = (state == dmaXferPkg::IDLE) || (state == dmaXferPkg::ADVANCE);
    assign lastCycle = (state == dmaXferPkg::DATA_LO) || (width == cpuBusPkg::PORT32);
    assign startLo   = (state == dmaXferPkg::WAIT_END) && (settleCnt == 2'd0) && narrow &&
                       (halfCnt != 2'(dmaXferPkg::MAX_HALVES));
    assign startCycle = (decide && owned && reqOk) || startLo;

    // hold the request for the whole transfer, drop it once the end is signalled
    assign wantBus = (state == dmaXferPkg::IDLE) ? reqOk : (state != dmaXferPkg::DONE);

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state     <= dmaXferPkg::IDLE;
            halfCnt   <= 2'd0;
            settleCnt <= 2'd0;
            narrow    <= 1'b0;
            xferEnd   <= 1'b0;
            pas       <= 1'b0;
            pds       <= 1'b0;
            size1     <= 1'b0;
            a1        <= 1'b0;
            f2cpuH    <= 1'b0;
            f2cpuL    <= 1'b0;
            plhw      <= 1'b0;
            pllw      <= 1'b0;
            incFifo   <= 1'b0;
            decFifo   <= 1'b0;
            incNi     <= 1'b0;
            incNo     <= 1'b0;
            stopFlush <= 1'b0;
        end else begin
            // single-cycle strobes
            xferEnd   <= 1'b0;
            plhw      <= 1'b0;
            pllw      <= 1'b0;
            incFifo   <= 1'b0;
            decFifo   <= 1'b0;
            incNi     <= 1'b0;
            incNo     <= 1'b0;
            stopFlush <= 1'b0;

            case (state)
                dmaXferPkg::IDLE, dmaXferPkg::ADVANCE: begin
                    if (!owned) begin
                        state <= dmaXferPkg::IDLE;
                    end else if (reqOk) begin
                        halfCnt <= 2'd0;    // fresh long word
                        state   <= dmaXferPkg::ADDR;
                    end else begin
                        xferEnd   <= 1'b1;
                        stopFlush <= flushWrite & fifoEmpty;    // flush drained
                        state     <= dmaXferPkg::DONE;
                    end
                end
                dmaXferPkg::ADDR: begin
                    pds   <= 1'b1;
                    state <= a1 ? dmaXferPkg::DATA_LO : dmaXferPkg::DATA_HI;
                end
                dmaXferPkg::DATA_HI, dmaXferPkg::DATA_LO: begin
                    if (cycDone) begin
                        pas     <= 1'b0;
                        pds     <= 1'b0;
                        f2cpuH  <= 1'b0;
                        f2cpuL  <= 1'b0;
                        halfCnt <= halfCnt + 2'd1;
                        if (state == dmaXferPkg::DATA_HI) begin
                            narrow <= (width == cpuBusPkg::PORT16);
                        end
                        if (!isWrite) begin
                            plhw <= (state == dmaXferPkg::DATA_HI);
                            pllw <= lastCycle;
                        end
                        // one bookkeeping pulse per long word
                        if (lastCycle) begin
                            incFifo <= ~isWrite;
                            incNi   <= ~isWrite;
                            decFifo <= isWrite;
                            incNo   <= isWrite;
                        end
                        settleCnt <= 2'(cpuBusPkg::SYNC_STAGES + 1);
                        state     <= dmaXferPkg::WAIT_END;
                    end
                end
                dmaXferPkg::WAIT_END: begin
                    if (settleCnt != 2'd0) begin
                        settleCnt <= settleCnt - 2'd1;    // let fifo flags come through sync
                    end else if (startLo) begin
                        state <= dmaXferPkg::ADDR;
                    end else begin
                        state <= dmaXferPkg::ADVANCE;
                    end
                end
                dmaXferPkg::DONE: begin
                    if (!owned) begin
                        state <= dmaXferPkg::IDLE;
                    end
                end
                default: begin
                    state <= dmaXferPkg::IDLE;
                end
            endcase

            // address phase of a new bus cycle
            if (startCycle) begin
                pas    <= 1'b1;
                a1     <= startLo;
                size1  <= startLo;    // word size on the second half
                f2cpuH <= isWrite & ~startLo;
                f2cpuL <= isWrite;
            end
        end
    end

endmodule

// File: sim/cpuSmChecker.sv
// watches the cpuSm ports, counts bus cycles and strobes per row and compares with expected counts
`timescale 1ns/1ps

module cpuSmChecker (
    input logic CLK135,
    input logic CCRESET_,
    input logic bgrantN,
    input logic bgackInN,
    input logic asN,
    input logic breq,
    input logic bgack,
    input logic pas,
    input logic size1,
    input logic a1,
    input logic f2cpuH,
    input logic f2cpuL,
    input logic plhw,
    input logic pllw,
    input logic incFifo,
    input logic decFifo,
    input logic incNi,
    input logic incNo,
    input logic stopFlush
);

    int  totalErrors = 0;
    int  rowsPassed = 0;
    int  rowsFailed = 0;
    int  rowErrs;
    int  rowIdx;
    logic active = 1'b0;
    logic narrowRow;
    logic sawBreq;
    logic expA1;
    logic pasQ, bgackQ;
    logic grantOkQ;    // grant and idle bus at the previous edge
    int  nCyc, nA1, nSize1, nF2cpuH, nF2cpuL, nPlhw, nPllw;
    int  nIncFifo, nDecFifo, nIncNi, nIncNo, nStop;

    always @(posedge CLK135) begin
        if (active) begin
            if (breq) sawBreq = 1'b1;
            if (pas && !pasQ) begin
                expA1 = narrowRow ? nCyc[0] : 1'b0;
                if (a1 !== expA1) begin
                    $display("FAIL row %0d a1 got %h exp %h", rowIdx, a1, expA1);
                    rowErrs++;
                end
                nCyc++;
                nA1     += a1;
                nSize1  += size1;
                nF2cpuH += f2cpuH;    // high half only on the first cycle of a word
                nF2cpuL += f2cpuL;
            end
            if (bgack && !bgackQ && !(sawBreq && grantOkQ)) begin
                $display("row %0d: bgack rose without a request and an idle granted bus",
                         rowIdx);
                rowErrs++;
            end
            nPlhw    += plhw;
            nPllw    += pllw;
            nIncFifo += incFifo;
            nDecFifo += decFifo;
            nIncNi   += incNi;
            nIncNo   += incNo;
            nStop    += stopFlush;
        end
        pasQ     = pas;
        bgackQ   = bgack;
        grantOkQ = !bgrantN && asN && bgackInN;
    end

    task automatic startRow(input int idx, input logic narrow);
        rowIdx = idx;
        narrowRow = narrow;
        rowErrs = 0;
        sawBreq = 1'b0;
        nCyc = 0;
        nA1 = 0;
        nSize1 = 0;
        nF2cpuH = 0;
        nF2cpuL = 0;
        nPlhw = 0;
        nPllw = 0;
        nIncFifo = 0;
        nDecFifo = 0;
        nIncNi = 0;
        nIncNo = 0;
        nStop = 0;
        active = 1'b1;
    endtask

    task automatic compareCount(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL row %0d %s got %h exp %h", rowIdx, name, got, exp);
            rowErrs++;
        end
    endtask

    task automatic endRow(input int cyc, input int halves, input int hiDrives,
                          input int loDrives, input int rd, input int wr, input int stops);
        active = 1'b0;
        compareCount("pas", nCyc, cyc);
        compareCount("a1", nA1, halves);
        compareCount("size1", nSize1, halves);
        compareCount("f2cpuH", nF2cpuH, hiDrives);
        compareCount("f2cpuL", nF2cpuL, loDrives);
        compareCount("plhw", nPlhw, rd);
        compareCount("pllw", nPllw, rd);
        compareCount("incFifo", nIncFifo, rd);
        compareCount("incNi", nIncNi, rd);
        compareCount("decFifo", nDecFifo, wr);
        compareCount("incNo", nIncNo, wr);
        compareCount("stopFlush", nStop, stops);
        if (rowErrs == 0) begin
            rowsPassed++;
            $display("row %0d PASS", rowIdx);
        end else begin
            rowsFailed++;
            $display("row %0d FAIL (%0d errors)", rowIdx, rowErrs);
        end
        totalErrors += rowErrs;
    endtask

    task automatic printCounts();
        $display("rows passed %0d, rows failed %0d, errors %0d",
                 rowsPassed, rowsFailed, totalErrors);
    endtask

endmodule

// File: sim/cpuSmTb.sv
// testbench for cpuSm, runs a table of transfers against bus slave and fifo level models
`timescale 1ns/1ps

module cpuSmTb;

    localparam int MAX_WAITS = 4;    // slave wait states are 0..MAX_WAITS-1
    localparam int NROWS = 8;
    localparam int DS32 = 0;
    localparam int DS16 = 1;
    localparam int STERM = 2;

    typedef struct packed {
        logic dir;       // 1 is FROM_FIFO
        int   mode;      // how the slave terminates
        int   n;         // long words
        logic flush;
        logic dreqStop;  // stop by dreqN instead of the fifo limit
        int   busy;      // cycles another master holds the bus
    } row_t;

    row_t rows [NROWS];

    logic CLK135 = 1'b0;
    logic CCRESET_;
    logic dmaEna, dreqN, dmaDir, flushFifo, fifoEmpty, fifoFull;
    logic bgrantN, bgackInN, asN;
    logic dsack0N = 1'b1;
    logic dsack1N = 1'b1;
    logic stermN = 1'b1;
    logic breq, bgack, pas, pds, size1, a1, f2cpuH, f2cpuL, plhw, pllw;
    logic incFifo, decFifo, incNi, incNo, stopFlush;

    int curMode = DS32;
    int waitLeft = 0;
    int busyLeft = 0;
    int pulses = 0;
    int curRow = 0;
    logic rowActive = 1'b0;
    int unsigned seedVal;

    always #4 CLK135 = ~CLK135;

    cpuSm DUT (.*);

    cpuSmChecker chk (
        .CLK135 (CLK135), .CCRESET_ (CCRESET_), .bgrantN (bgrantN), .bgackInN (bgackInN),
        .asN (asN), .breq (breq), .bgack (bgack), .pas (pas), .size1 (size1), .a1 (a1),
        .f2cpuH (f2cpuH), .f2cpuL (f2cpuL),
        .plhw (plhw), .pllw (pllw), .incFifo (incFifo), .decFifo (decFifo),
        .incNi (incNi), .incNo (incNo), .stopFlush (stopFlush)
    );

    // bus slave answers each pas after a random number of wait states
    task automatic answerBus();
        if (!pas) begin
            {stermN, dsack1N, dsack0N} = 3'b111;
            waitLeft = $urandom % MAX_WAITS;
        end else if (waitLeft != 0) begin
            waitLeft--;
        end else begin
            case (curMode)
                DS16:    dsack1N = 1'b0;    // narrow port
                STERM:   stermN = 1'b0;
                default: {dsack1N, dsack0N} = 2'b00;
            endcase
        end
    endtask

    // one falling edge of the slave, grant, other master and fifo level models
    task automatic tick();
        @(negedge CLK135);
        answerBus();
        bgrantN = ~breq;
        if (busyLeft > 0) begin
            busyLeft--;
        end else begin
            bgackInN = 1'b1;
            asN = 1'b1;
        end
        if (rowActive && (incFifo || decFifo)) begin
            pulses++;
            if (pulses == rows[curRow].n) begin
                if (rows[curRow].dreqStop) dreqN = 1'b1;
                else if (rows[curRow].dir) fifoEmpty = 1'b1;
                else fifoFull = 1'b1;
            end
        end
    endtask

    task automatic ticks(input int count);
        repeat (count) tick();
    endtask

    task automatic runRow(input int idx);
        row_t r;
        int halves;
        int cycles;
        r = rows[idx];
        curRow = idx;
        curMode = r.mode;
        pulses = 0;
        dmaDir = r.dir;
        flushFifo = r.flush;
        dreqN = r.flush;    // a flush runs without a peripheral request
        busyLeft = r.busy;
        bgackInN = (r.busy == 0);
        asN = (r.busy == 0);
        chk.startRow(idx, r.mode == DS16);
        rowActive = 1'b1;
        dmaEna = 1'b1;
        while (!bgack) tick();
        while (bgack) tick();
        dmaEna = 1'b0;
        dreqN = 1'b1;
        flushFifo = 1'b0;
        ticks(6);
        fifoFull = 1'b0;
        fifoEmpty = 1'b0;
        rowActive = 1'b0;
        ticks(6);
        halves = (r.mode == DS16) ? r.n : 0;
        cycles = r.n + halves * (dmaXferPkg::MAX_HALVES - 1);
        chk.endRow(cycles, halves, r.dir ? r.n : 0, r.dir ? cycles : 0,
                   r.dir ? 0 : r.n, r.dir ? r.n : 0, r.flush ? 1 : 0);
    endtask

    function automatic longint budgetCycles();
        longint total;
        total = 20;    // reset and start-up
        for (int i = 0; i < NROWS; i++) begin
            total += rows[i].n * 2 * (MAX_WAITS + 8) + 40 + rows[i].busy;
        end
        return total;
    endfunction

    initial begin
        rows[0] = '{1'b0, DS32, 3, 1'b0, 1'b0, 10};    // arbitration behind another master
        rows[1] = '{1'b0, DS32, 4, 1'b0, 1'b0, 0};
        rows[2] = '{1'b1, DS16, 3, 1'b0, 1'b0, 0};
        rows[3] = '{1'b0, STERM, 3, 1'b0, 1'b0, 0};
        rows[4] = '{1'b0, DS32, 2, 1'b0, 1'b1, 0};     // dreqN back-pressure
        rows[5] = '{1'b1, DS32, 3, 1'b1, 1'b0, 0};     // flush
        rows[6] = '{1'b0, DS16, 2, 1'b0, 1'b0, 0};
        rows[7] = '{1'b1, STERM, 2, 1'b0, 1'b1, 0};
        seedVal = $urandom(32'hb7a27e9d);
        CCRESET_ = 1'b0;
        dmaEna = 1'b0;
        dreqN = 1'b1;
        dmaDir = 1'b0;
        flushFifo = 1'b0;
        fifoEmpty = 1'b0;
        fifoFull = 1'b0;
        bgrantN = 1'b1;
        bgackInN = 1'b1;
        asN = 1'b1;
        repeat (4) @(negedge CLK135);
        CCRESET_ = 1'b1;
        ticks(4);
        for (int i = 0; i < NROWS; i++) begin
            runRow(i);
        end
        chk.printCounts();
        if (chk.totalErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        #1;
        #(budgetCycles() * 8);
        $display("timeout: the transfers did not finish within the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: sim/cpuSm_properties.sv
// concurrent checks on the cpu sequencer top outputs, bound into every cpuSm instance
`timescale 1ns/1ps

module cpuSmProperties (
    input logic CLK135,
    input logic CCRESET_,
    input logic breq,
    input logic bgack,
    input logic pas,
    input logic pds,
    input logic incFifo,
    input logic decFifo
);

    noBreqWithBgack: assert property (@(posedge CLK135) disable iff (!CCRESET_)
        !(breq && bgack)) else $error("breq and bgack high together");

    pdsNeedsPas: assert property (@(posedge CLK135) disable iff (!CCRESET_)
        pds |-> pas) else $error("pds high without pas");

    incFifoOneCycle: assert property (@(posedge CLK135) disable iff (!CCRESET_)
        incFifo |=> !incFifo) else $error("incFifo longer than one cycle");

    decFifoOneCycle: assert property (@(posedge CLK135) disable iff (!CCRESET_)
        decFifo |=> !decFifo) else $error("decFifo longer than one cycle");

endmodule

bind cpuSm cpuSmProperties props (
    .CLK135   (CLK135),
    .CCRESET_ (CCRESET_),
    .breq     (breq),
    .bgack    (bgack),
    .pas      (pas),
    .pds      (pds),
    .incFifo  (incFifo),
    .decFifo  (decFifo)
);

// File: src/busArbiter.sv
// bus request, grant and acknowledge state machine, instantiated by the cpu sequencer top
`timescale 1ns/1ps

module busArbiter (
    input  logic CLK135,
    input  logic CCRESET_,
    input  logic wantBus,
    input  logic bgrantN,
    input  logic bgackInN,
    input  logic asN,
    input  logic xferEnd,
    output logic breq,
    output logic bgack,
    output logic owned
);

    cpuBusPkg::arbState_e state;
    cpuBusPkg::arbState_e nextState;
    logic busIdle;

    assign busIdle = asN & bgackInN;    // no strobe and no other master

    always_comb begin
        nextState = state;
        case (state)
            cpuBusPkg::IDLE: begin
                if (wantBus) begin
                    nextState = cpuBusPkg::REQUEST;
                end
            end
            cpuBusPkg::REQUEST: begin
                if (!bgrantN && busIdle) begin
                    nextState = cpuBusPkg::OWNED;    // grant wins over a late withdraw
                end else if (!wantBus) begin
                    nextState = cpuBusPkg::IDLE;
                end
            end
            cpuBusPkg::OWNED: begin
                if (xferEnd) begin
                    nextState = cpuBusPkg::RELEASE;
                end
            end
            cpuBusPkg::RELEASE: begin
                nextState = cpuBusPkg::IDLE;
            end
            default: begin
                nextState = cpuBusPkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state <= cpuBusPkg::IDLE;
        end else begin
            state <= nextState;
        end
    end

    // outputs decode straight from the state register
    assign breq  = (state == cpuBusPkg::REQUEST);
    assign bgack = (state == cpuBusPkg::OWNED);
    assign owned = (state == cpuBusPkg::OWNED);    // sequencer's view of ownership

endmodule

// File: src/cycleTerminator.sv
// synchronizes DSACK0/DSACK1/STERM and turns them into one cycle-done pulse with the port width
`timescale 1ns/1ps

module cycleTerminator (
    input  logic                  CLK135,
    input  logic                  CCRESET_,
    input  logic                  pas,
    input  logic                  dsack0N,
    input  logic                  dsack1N,
    input  logic                  stermN,
    output logic                  cycDone,
    output cpuBusPkg::portWidth_e width
);

    logic [2:0] termSync [cpuBusPkg::SYNC_STAGES];    // {stermN, dsack1N, dsack0N}
    logic [2:0] termNow;
    logic       anyTerm;
    logic       allNegated;
    logic       armed;

    assign termNow    = termSync[cpuBusPkg::SYNC_STAGES-1];
    assign anyTerm    = ~&termNow;    // any terminator low
    assign allNegated = &termNow;

    always_ff @(posedge CLK135 or negedge CCRESET_) begin
        if (!CCRESET_) begin
            for (int i = 0; i < cpuBusPkg::SYNC_STAGES; i++) begin
                termSync[i] <= 3'b111;
            end
            armed <= 1'b0;
        end else begin
            termSync[0] <= {stermN, dsack1N, dsack0N};
            for (int i = 1; i < cpuBusPkg::SYNC_STAGES; i++) begin
                termSync[i] <= termSync[i-1];
            end
            // disarm on the pulse, re-arm only once the slave lets go
            if (cycDone) begin
                armed <= 1'b0;
            end else if (allNegated) begin
                armed <= 1'b1;
            end
        end
    end

    assign cycDone = armed & pas & anyTerm;

    // dsack1 alone means a 16-bit port, everything else is full width
    assign width = (termNow == 3'b101) ? cpuBusPkg::PORT16 : cpuBusPkg::PORT32;

endmodule
